//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/block_ram.sv
`timescale 1ns/1ns
`default_nettype none

module block_ram
	import mem_pkg::*;
(
	input  logic     clk,
	input  bus_req_t ram_req,                   // Idle when nobody is granted
	output word_t    bus_rdata,
	output logic     bus_ready                  // High the cycle after accept
);

	word_t mem [RAM_WORDS];                     // Contents start unknown

	logic [RAM_ADDR_W-1:0] ram_idx;
	logic                  accept;

	assign ram_idx = ram_index(ram_req.addr);

	// Request stays up during the ready cycle, so skip it there
	assign accept = (ram_req.op != BUS_IDLE) && !bus_ready;

	always_ff @(posedge clk)
	begin
		bus_ready <= accept;                    // Idle bus in reset clears it
		if (accept)
		begin
			if (ram_req.op == BUS_WRITE)
				mem[ram_idx] <= ram_req.wdata;
			bus_rdata <= mem[ram_idx];           // Old word on writes
		end
	end

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
	import mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] bus_req,                 // Bit per master, see master_e
	input  bus_req_t   ic_bus,
	input  bus_req_t   dc_bus,
	input  logic       bus_ready,               // RAM transfer done
	output logic [1:0] bus_ack,                 // Grant vector
	output bus_req_t   ram_req                  // Steered request
);

	arb_state_e state;
	arb_state_e state_next;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;                     // Hold by default
		case (state)
			ARB_IDLE:
			begin
				if (bus_req[MASTER_DCACHE])         // Data side wins a tie
					state_next = ARB_DCACHE;
				else if (bus_req[MASTER_ICACHE])
					state_next = ARB_ICACHE;
			end
			ARB_DCACHE, ARB_ICACHE:
			begin
				if (bus_ready)                      // One transfer per grant
					state_next = ARB_IDLE;
			end
			default:
				state_next = ARB_IDLE;
		endcase
	end

	always_comb
	begin
		bus_ack = '0;
		bus_ack[MASTER_DCACHE] = (state == ARB_DCACHE);
		bus_ack[MASTER_ICACHE] = (state == ARB_ICACHE);
	end

	always_comb
	begin
		case (state)
			ARB_DCACHE: ram_req = dc_bus;
			ARB_ICACHE: ram_req = ic_bus;
			default:    ram_req = BUS_REQ_IDLE; // Nothing granted
		endcase
	end

	// Only one master may own the bus
	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(bus_ack));

	// A grant always has a live request behind it
	a_grant_requested: assert property (@(posedge clk) disable iff (rst)
		(bus_ack & ~bus_req) == 2'b00);

endmodule

`default_nettype wire

//--- hw/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	input  dc_req_t  req,
	output logic     req_ready,
	output logic     rsp_valid,                 // Read data or write done
	output word_t    rsp_data,                  // Zero for writes
	output logic     bus_req,
	input  logic     bus_ack,
	output bus_req_t bus_out,
	input  word_t    bus_rdata,
	input  logic     bus_ready
);

	cache_state_e state;

	logic [CACHE_LINES-1:0] valid;
	logic [TAG_W-1:0]       tag_arr [CACHE_LINES];
	word_t                  data_arr [CACHE_LINES];

	dc_req_t            req_q;                  // Accepted request
	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0]   tag;
	logic               is_write;
	logic               hit;
	logic               bus_done;
	logic               pending;                // Accepted, not yet answered

	assign idx = addr_index(req_q.addr);
	assign tag = addr_tag(req_q.addr);
	assign is_write = (req_q.op == BUS_WRITE);
	assign hit = valid[idx] && (tag_arr[idx] == tag);
	assign bus_done = (state == CACHE_BUS) && bus_ack && bus_ready;

	assign req_ready = (state == CACHE_IDLE);
	assign rsp_valid = (state == CACHE_RESPOND);
	assign bus_req = (state == CACHE_BUS);

	always_comb
	begin
		if (state == CACHE_BUS)
		begin
			bus_out.op = is_write ? BUS_WRITE : BUS_READ;
			bus_out.addr = req_q.addr;
			bus_out.wdata = req_q.wdata;
		end
		else
			bus_out = BUS_REQ_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= CACHE_IDLE;
			valid <= '0;
		end
		else
		begin
			case (state)
				CACHE_IDLE:
					if (req_valid)
						state <= CACHE_LOOKUP;
				CACHE_LOOKUP:
				begin
					if (!is_write && hit)
						state <= CACHE_RESPOND;       // Read hit answers in two cycles
					else
						state <= CACHE_BUS;           // Read miss or write through
				end
				CACHE_BUS:
				begin
					if (bus_done)
					begin
						if (!is_write)
							valid[idx] <= 1'b1;         // No write allocate
						state <= CACHE_RESPOND;
					end
				end
				default:
					state <= CACHE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
			req_q <= req;
		if (state == CACHE_LOOKUP && hit)
		begin
			if (is_write)
				data_arr[idx] <= req_q.wdata;       // Keep hit line current
			else
				rsp_data <= data_arr[idx];
		end
		if (bus_done)
		begin
			if (is_write)
				rsp_data <= '0;
			else
			begin
				tag_arr[idx] <= tag;
				data_arr[idx] <= bus_rdata;
				rsp_data <= bus_rdata;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= 1'b0;
		else if (req_valid && req_ready)
			pending <= 1'b1;
		else if (rsp_valid)
			pending <= 1'b0;
	end

	// Every response answers an earlier handshake
	a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
		rsp_valid |-> pending);

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     req_valid,
	input  addr_t    req_addr,
	output logic     req_ready,
	output logic     rsp_valid,                 // One-cycle pulse
	output word_t    rsp_data,
	output logic     bus_req,
	input  logic     bus_ack,                   // Our grant bit
	output bus_req_t bus_out,
	input  word_t    bus_rdata,
	input  logic     bus_ready
);

	cache_state_e state;

	logic [CACHE_LINES-1:0] valid;              // Cleared in reset
	logic [TAG_W-1:0]       tag_arr [CACHE_LINES];
	word_t                  data_arr [CACHE_LINES];

	addr_t              addr_q;                 // Accepted fetch address
	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0]   tag;
	logic               hit;
	logic               bus_done;

	assign idx = addr_index(addr_q);
	assign tag = addr_tag(addr_q);
	assign hit = valid[idx] && (tag_arr[idx] == tag);
	assign bus_done = (state == CACHE_BUS) && bus_ack && bus_ready;

	assign req_ready = (state == CACHE_IDLE);   // Low until response ends
	assign rsp_valid = (state == CACHE_RESPOND);
	assign bus_req = (state == CACHE_BUS);      // Drops the cycle after ready

	always_comb
	begin
		if (state == CACHE_BUS)
			bus_out = '{op: BUS_READ, addr: addr_q, wdata: '0};
		else
			bus_out = BUS_REQ_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= CACHE_IDLE;
			valid <= '0;
		end
		else
		begin
			case (state)
				CACHE_IDLE:
					if (req_valid)
						state <= CACHE_LOOKUP;
				CACHE_LOOKUP:
					state <= hit ? CACHE_RESPOND : CACHE_BUS;
				CACHE_BUS:
				begin
					if (bus_done)
					begin
						valid[idx] <= 1'b1;           // Line now filled
						state <= CACHE_RESPOND;
					end
				end
				default:
					state <= CACHE_IDLE;          // Response cycle over
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid && req_ready)
			addr_q <= req_addr;
		if (state == CACHE_LOOKUP && hit)
			rsp_data <= data_arr[idx];           // Hit path
		if (bus_done)
		begin
			tag_arr[idx] <= tag;                 // Refill overwrites old line
			data_arr[idx] <= bus_rdata;
			rsp_data <= bus_rdata;
		end
	end

	// Fetch side is read only
	a_no_write: assert property (@(posedge clk) disable iff (rst)
		bus_out.op != BUS_WRITE);

endmodule

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

	localparam int ADDR_W      = 32;            // Byte address width
	localparam int DATA_W      = 32;            // Word width
	localparam int CACHE_LINES = 16;            // One-word lines per cache
	localparam int INDEX_W     = 4;             // Address bits 5:2
	localparam int TAG_W       = 6;             // Address bits 11:6
	localparam int RAM_WORDS   = 1024;          // Block RAM depth
	localparam int RAM_ADDR_W  = 10;            // Address bits 11:2
	localparam int BYTE_OFF_W  = 2;             // Byte lanes, ignored

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;

	typedef enum logic [1:0] {
		BUS_IDLE  = 2'd0,                       // Must stay zero, idle bus is all zeros
		BUS_READ  = 2'd1,
		BUS_WRITE = 2'd2
	} bus_op_e;

	typedef enum int {
		MASTER_DCACHE = 0,                      // Bit 0 of request and grant
		MASTER_ICACHE = 1                       // Bit 1 of request and grant
	} master_e;

	typedef struct packed {
		bus_op_e op;
		addr_t   addr;
		word_t   wdata;
	} bus_req_t;                                // 66 bits toward the RAM

	typedef struct packed {
		bus_op_e op;
		addr_t   addr;
		word_t   wdata;
	} dc_req_t;                                 // Load/store port request

	typedef enum logic [1:0] {ARB_IDLE, ARB_ICACHE, ARB_DCACHE} arb_state_e;

	typedef enum logic [1:0] {CACHE_IDLE, CACHE_LOOKUP, CACHE_BUS, CACHE_RESPOND} cache_state_e;

	localparam bus_req_t BUS_REQ_IDLE = '{op: BUS_IDLE, addr: '0, wdata: '0};

	function automatic logic [INDEX_W-1:0] addr_index(addr_t a);
		return a[BYTE_OFF_W +: INDEX_W];       // Cache line select
	endfunction

	function automatic logic [TAG_W-1:0] addr_tag(addr_t a);
		return a[BYTE_OFF_W+INDEX_W +: TAG_W]; // Upper bits alias
	endfunction

	function automatic logic [RAM_ADDR_W-1:0] ram_index(addr_t a);
		return a[BYTE_OFF_W +: RAM_ADDR_W];    // RAM word select
	endfunction

endpackage

`default_nettype wire

//--- hw/mem_system.sv
`timescale 1ns/1ns
`default_nettype none

module mem_system
	import mem_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    ic_req_valid,
	input  addr_t   ic_req_addr,
	output logic    ic_req_ready,
	output logic    ic_rsp_valid,
	output word_t   ic_rsp_data,
	input  logic    dc_req_valid,
	input  dc_req_t dc_req,
	output logic    dc_req_ready,
	output logic    dc_rsp_valid,
	output word_t   dc_rsp_data
);

	wire [1:0] bus_req;                         // Bit 0 dcache, bit 1 icache
	wire [1:0] bus_ack;
	bus_req_t  ic_bus;
	bus_req_t  dc_bus;
	bus_req_t  ram_req;                         // Granted master's request
	word_t     bus_rdata;                       // Shared by both caches
	logic      bus_ready;

	icache i_icache (
		.clk       (clk),
		.rst       (rst),
		.req_valid (ic_req_valid),
		.req_addr  (ic_req_addr),
		.req_ready (ic_req_ready),
		.rsp_valid (ic_rsp_valid),
		.rsp_data  (ic_rsp_data),
		.bus_req   (bus_req[MASTER_ICACHE]),
		.bus_ack   (bus_ack[MASTER_ICACHE]),
		.bus_out   (ic_bus),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

	dcache i_dcache (
		.clk       (clk),
		.rst       (rst),
		.req_valid (dc_req_valid),
		.req       (dc_req),
		.req_ready (dc_req_ready),
		.rsp_valid (dc_rsp_valid),
		.rsp_data  (dc_rsp_data),
		.bus_req   (bus_req[MASTER_DCACHE]),
		.bus_ack   (bus_ack[MASTER_DCACHE]),
		.bus_out   (dc_bus),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

	bus_arbiter i_bus_arbiter (
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.ic_bus    (ic_bus),
		.dc_bus    (dc_bus),
		.bus_ready (bus_ready),
		.bus_ack   (bus_ack),
		.ram_req   (ram_req)
	);

	block_ram i_block_ram (
		.clk       (clk),
		.ram_req   (ram_req),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

endmodule

`default_nettype wire

//--- list.f
hw/mem_pkg.sv
hw/bus_arbiter.sv
hw/icache.sv
hw/dcache.sv
hw/block_ram.sv
hw/mem_system.sv
verification/tb_mem_system.sv

//--- verification/tb_mem_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_system
	import mem_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS  = 6;
	localparam int RAND_OPS   = 80;
	localparam int WAIT_MAX   = 100;            // Cycles before a stuck port is declared dead

	logic    clk;
	logic    rst;
	logic    ic_req_valid;
	addr_t   ic_req_addr;
	logic    ic_req_ready;
	logic    ic_rsp_valid;
	word_t   ic_rsp_data;
	logic    dc_req_valid;
	dc_req_t dc_req;
	logic    dc_req_ready;
	logic    dc_rsp_valid;
	word_t   dc_rsp_data;

	word_t ref_mem [RAM_WORDS];                 // RAM model indexed by addr[11:2]
	bit    written [RAM_WORDS];                 // Word has a known value
	bit    fetched [RAM_WORDS];                 // Icache may hold a copy
	int    seed = 32'ha62f;

	mem_system i_dut (.*);

	initial
		clk = 1'b0;
	always
		#(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(string what);
		$display("%0t ns: %s", $time, what);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_latency(string name, int expected, int actual);
		if (actual != expected)
		begin
			$display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Entered and left on a falling edge
	// Latency counts cycles from the handshake edge
	task automatic dc_access(bus_op_e op, addr_t addr, word_t wdata, output int latency);
		int waited = 0;
		dc_req_valid = 1'b1;
		dc_req = '{op: op, addr: addr, wdata: wdata};
		while (!dc_req_ready)                   // Held while back-pressured
		begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_MAX)
				abort_run("data port never became ready");
		end
		@(negedge clk);                         // Handshake edge now behind us
		dc_req_valid = 1'b0;
		latency = 1;
		while (!dc_rsp_valid)
		begin
			@(negedge clk);
			latency++;
			if (latency > WAIT_MAX)
				abort_run("data port response never arrived");
		end
		if (op == BUS_WRITE)
		begin
			check_word("dc_rsp_data", '0, dc_rsp_data);  // Writes answer zero
			ref_mem[addr[11:2]] = wdata;
			written[addr[11:2]] = 1'b1;
		end
		else
			check_word("dc_rsp_data", ref_mem[addr[11:2]], dc_rsp_data);
		@(negedge clk);
		check_bit("dc_rsp_valid", 1'b0, dc_rsp_valid);    // One pulse only
	endtask

	task automatic ic_fetch(addr_t addr, output int latency);
		int waited = 0;
		ic_req_valid = 1'b1;
		ic_req_addr = addr;
		while (!ic_req_ready)
		begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_MAX)
				abort_run("instruction port never became ready");
		end
		@(negedge clk);
		ic_req_valid = 1'b0;
		latency = 1;
		while (!ic_rsp_valid)
		begin
			@(negedge clk);
			latency++;
			if (latency > WAIT_MAX)
				abort_run("instruction port response never arrived");
		end
		check_word("ic_rsp_data", ref_mem[addr[11:2]], ic_rsp_data);
		fetched[addr[11:2]] = 1'b1;
		@(negedge clk);
		check_bit("ic_rsp_valid", 1'b0, ic_rsp_valid);
	endtask

	task automatic after_reset();
		check_bit("ic_req_ready", 1'b1, ic_req_ready);
		check_bit("dc_req_ready", 1'b1, dc_req_ready);
		check_bit("ic_rsp_valid", 1'b0, ic_rsp_valid);
		check_bit("dc_rsp_valid", 1'b0, dc_rsp_valid);
	endtask

	task automatic write_then_read();
		int lat;
		dc_access(BUS_WRITE, 32'h0000_0104, 32'hcafe_0001, lat);
		dc_access(BUS_READ, 32'h0000_0104, '0, lat);     // Misses since writes do not allocate
		dc_access(BUS_READ, 32'h0000_0104, '0, lat);
		check_latency("dc hit latency", 2, lat);
	endtask

	task automatic fetch_written_word();
		int lat;
		dc_access(BUS_WRITE, 32'h0000_0208, 32'h1234_5678, lat);
		ic_fetch(32'h0000_0208, lat);
		ic_fetch(32'h0000_0208, lat);
		check_latency("ic hit latency", 2, lat);
	endtask

	task automatic conflict_eviction();
		int lat;
		dc_access(BUS_WRITE, 32'h0000_0314, 32'h5a5a_0314, lat);  // Index 5, tag 12
		dc_access(BUS_WRITE, 32'h0000_0354, 32'ha5a5_0354, lat);  // Index 5, tag 13
		for (int round = 0; round < 2; round++)
		begin
			dc_access(BUS_READ, 32'h0000_0314, '0, lat);
			ic_fetch(32'h0000_0354, lat);
			dc_access(BUS_READ, 32'h8000_0354, '0, lat);          // Upper bits alias
			ic_fetch(32'h0000_0314, lat);
		end
	endtask

	task automatic simultaneous_misses();
		int lat_i;
		int lat_d;
		dc_access(BUS_WRITE, 32'h0000_0420, 32'h0bad_f00d, lat_d);
		dc_access(BUS_WRITE, 32'h0000_0530, 32'h600d_cafe, lat_d);
		fork                                    // Both miss in the same cycle
			ic_fetch(32'h0000_0420, lat_i);
			dc_access(BUS_READ, 32'h0000_0530, '0, lat_d);
		join
	endtask

	task automatic random_traffic();
		addr_t                 addr;
		logic [RAM_ADDR_W-1:0] widx;
		int                    kind;
		int                    lat;
		for (int i = 0; i < RAND_OPS; i++)
		begin
			addr = $random(seed);
			addr[11:8] = 4'h0;                  // Only 64 words so lines conflict often
			widx = addr[11:2];
			kind = $unsigned($random(seed)) % 3;
			// Never write a word the icache may hold
			if (!written[widx] || (kind == 0 && !fetched[widx]))
				dc_access(BUS_WRITE, addr, $random(seed), lat);
			else if (kind == 1)
				dc_access(BUS_READ, addr, '0, lat);
			else
				ic_fetch(addr, lat);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		ic_req_valid = 1'b0;
		ic_req_addr = '0;
		dc_req_valid = 1'b0;
		dc_req = '0;
		repeat (5) @(posedge clk);              // Five rising edges in reset
		@(negedge clk);
		rst = 1'b0;
		after_reset();
		write_then_read();
		fetch_written_word();
		conflict_eviction();
		simultaneous_misses();
		random_traffic();
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial
	begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", NUM_TESTS * 200);
		$display("SOME TESTS FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire
